// File: verilog.f
source/csr_map_pkg.sv
source/csr_op_pkg.sv
source/csr_regs.sv
source/csr_timer.sv
source/csr_trap.sv
source/csr_unit.sv
verif/csr_unit_properties.sv
verif/csr_unit_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = csr_unit_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_tb
    import csr_map_pkg::*;
    import csr_op_pkg::*;
;

    localparam int req_budget  = 120;
    localparam int watchdog_ns = (8 + req_budget * 6 + 50) * 100;

    logic            clk;
    logic            rstn;
    logic            req_valid;
    csr_op_e         req_op;
    csr_arg_u        req_arg;
    logic [xlen-1:0] req_pc;
    logic [xlen-1:0] req_din;
    logic [xlen-1:0] req_mask;
    logic [xlen-1:0] req_badv;
    logic            stall;
    logic [7:0]      hw_int;
    logic [xlen-1:0] rdata;
    logic            flush;
    logic [xlen-1:0] redirect_pc;
    logic            excp_flush;
    logic            ertn_flush;
    logic [8:0]      crmd;

    // reference model state
    logic [8:0]      m_crmd = crmd_reset;
    logic [2:0]      m_prmd = '0;
    logic [11:0]     m_lie = '0;
    logic [5:0]      m_ecode = '0;
    logic [8:0]      m_esub = '0;
    logic [xlen-1:0] m_era = '0;
    logic [xlen-1:0] m_badv = '0;
    logic [xlen-1:0] m_eentry = '0;
    logic [xlen-1:0] m_save [0:3];
    logic [xlen-1:0] m_tid = '0;
    logic [xlen-1:0] m_tcfg = '0;
    logic            ti_armed = 1'b0;
    int              ti_fire = 0;    // first issue edge that sees the timer line

    logic            chk_stage = 1'b0;
    logic [xlen-1:0] exp_rdata = '0;
    logic            exp_flush = 1'b0;
    logic [xlen-1:0] exp_redirect = '0;
    logic            exp_excp = 1'b0;
    logic            exp_ertn = 1'b0;
    logic [31:0]     lfsr = 32'h4937;
    int              cyc = 0;
    int              int_count = 0;

    csr_unit #(
        .timer_n (32)
    ) dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_arg     (req_arg),
        .req_pc      (req_pc),
        .req_din     (req_din),
        .req_mask    (req_mask),
        .req_badv    (req_badv),
        .stall       (stall),
        .hw_int      (hw_int),
        .rdata       (rdata),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .crmd        (crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic report_error(input string msg);
        $display(">>> FAIL");
        $display("error %0t: %s", $time, msg);
        $fatal(1, "stopped at first error");
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic csr_arg_u num_arg(input logic [csr_num_w-1:0] num);
        csr_arg_u a;
        a         = '0;
        a.csr.num = num;
        return a;
    endfunction

    function automatic csr_arg_u excp_arg(input logic [5:0] ecode, input logic [8:0] esub);
        csr_arg_u a;
        a               = '0;
        a.excp.ecode    = ecode;
        a.excp.esubcode = esub;
        return a;
    endfunction

    function automatic logic ti_live(input int edge_no);
        return ti_armed && edge_no >= ti_fire;
    endfunction

    function automatic logic int_due(input int edge_no);
        logic [11:0] is_vec;
        is_vec = {ti_live(edge_no), 1'b0, hw_int, 2'b00};
        return (|(is_vec & m_lie)) && m_crmd[2];
    endfunction

    function automatic logic [xlen-1:0] model_read(input logic [csr_num_w-1:0] num,
                                                   input int edge_no);
        case (num)
            csr_crmd:   return {23'd0, m_crmd};
            csr_prmd:   return {29'd0, m_prmd};
            csr_ecfg:   return {20'd0, m_lie};
            csr_estat:  return {1'b0, m_esub, m_ecode, 4'b0000, ti_live(edge_no), 1'b0,
                                hw_int, 2'b00};
            csr_era:    return m_era;
            csr_badv:   return m_badv;
            csr_eentry: return m_eentry;
            csr_save0:  return m_save[0];
            csr_save1:  return m_save[1];
            csr_save2:  return m_save[2];
            csr_save3:  return m_save[3];
            csr_tid:    return m_tid;
            csr_tcfg:   return m_tcfg;
            default:    return '0;
        endcase
    endfunction

    task automatic model_commit(input csr_op_e op, input csr_arg_u arg,
                                input logic [xlen-1:0] pc, input logic [xlen-1:0] w,
                                input logic [xlen-1:0] badv, input int edge_no);
        case (op)
            op_excp, op_int:
            begin
                m_prmd      = m_crmd[2:0];
                m_crmd[2:0] = 3'b000;
                m_ecode     = arg.excp.ecode;
                m_esub      = arg.excp.esubcode;
                m_era       = pc;
                if (arg.excp.ecode == ecode_ale || arg.excp.ecode == ecode_ade)
                    m_badv = badv;
            end
            op_ertn: m_crmd[2:0] = m_prmd;
            op_csrwr, op_csrxchg:
            begin
                case (arg.csr.num)
                    csr_crmd:
                    begin
                        m_crmd[2:0] = w[2:0];
                        m_crmd[8:5] = w[8:5];
                        if (w[4] ^ w[3])
                            m_crmd[4:3] = w[4:3];
                    end
                    csr_prmd:   m_prmd = w[2:0];
                    csr_ecfg:   m_lie = w[11:0] & 12'hbff;
                    csr_era:    m_era = w;
                    csr_badv:   m_badv = w;
                    csr_eentry: m_eentry = {w[31:6], 6'd0};
                    csr_save0:  m_save[0] = w;
                    csr_save1:  m_save[1] = w;
                    csr_save2:  m_save[2] = w;
                    csr_save3:  m_save[3] = w;
                    csr_tid:    m_tid = w;
                    csr_tcfg:
                    begin
                        m_tcfg   = w;
                        ti_armed = w[0];    // one-shot only
                        ti_fire  = edge_no + 3 + int'({w[31:2], 2'b00});
                    end
                    csr_ticlr:
                    begin
                        if (w[0])
                            ti_armed = 1'b0;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    endtask

    // called at a falling edge and returns at the falling edge after commit
    task automatic run_req(input csr_op_e op, input csr_arg_u arg, input logic [xlen-1:0] din,
                           input logic [xlen-1:0] mask, input logic [xlen-1:0] badv);
        logic [31:0]     tmp;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] old;
        logic [xlen-1:0] wdata;
        logic            take;
        csr_op_e         eff;
        csr_arg_u        earg;
        int              issue_edge;
        int              gap;
        tmp        = next_bits(30);
        pc         = {tmp[29:0], 2'b00};
        issue_edge = cyc + 1;
        old        = model_read(arg.csr.num, issue_edge);
        take       = int_due(issue_edge);
        eff        = take ? op_int : op;
        earg       = take ? excp_arg(ecode_int, 9'd0) : arg;
        wdata      = (op == op_csrwr) ? din : ((old & ~mask) | (din & mask));
        req_valid  = 1'b1;
        req_op     = op;
        req_arg    = arg;
        req_pc     = pc;
        req_din    = din;
        req_mask   = mask;
        req_badv   = badv;
        stall      = 1'b0;
        @(negedge clk);
        exp_excp  = 1'b0;
        exp_ertn  = 1'b0;
        chk_stage = 1'b1;
        exp_rdata = old;
        exp_flush = (eff != op_csrrd);
        case (eff)
            op_ertn:         exp_redirect = m_era;
            op_excp, op_int: exp_redirect = m_eentry;
            default:         exp_redirect = pc + 32'd4;
        endcase
        tmp   = next_bits(2);
        gap   = int'(tmp[1:0]);
        stall = (gap != 0);
        repeat (gap)
        begin
            // stray requests under stall must not be taken
            tmp       = next_bits(1);
            req_valid = tmp[0];
            req_op    = op_csrwr;
            req_arg   = num_arg(csr_save0);
            req_din   = next_bits(32);
            @(negedge clk);
        end
        stall     = 1'b0;
        req_valid = 1'b0;
        @(negedge clk);
        chk_stage = 1'b0;
        exp_excp  = (eff == op_excp || eff == op_int);
        exp_ertn  = (eff == op_ertn);
        model_commit(eff, earg, pc, wdata, badv, cyc);
        if (excp_flush && op != op_excp)
            int_count++;    // interrupt entry seen at the dut
    endtask

    task automatic write_csr(input logic [csr_num_w-1:0] num, input logic [xlen-1:0] data);
        run_req(op_csrwr, num_arg(num), data, '1, '0);
    endtask

    task automatic read_csr(input logic [csr_num_w-1:0] num);
        run_req(op_csrrd, num_arg(num), '0, '0, '0);
    endtask

    a_reset_out: assert property (@(posedge clk)
        $rose(rstn) |-> (rdata == '0 && !flush && !excp_flush && !ertn_flush))
        else report_error("outputs not cleared by reset");

    a_rdata: assert property (@(posedge clk) disable iff (!rstn)
        chk_stage |-> rdata == exp_rdata)
        else report_error($sformatf("rdata %h, expected %h", $sampled(rdata), exp_rdata));

    a_flush: assert property (@(posedge clk) disable iff (!rstn)
        chk_stage |-> flush == exp_flush)
        else report_error($sformatf("flush %b, expected %b", $sampled(flush), exp_flush));

    a_redirect: assert property (@(posedge clk) disable iff (!rstn)
        chk_stage |-> redirect_pc == exp_redirect)
        else report_error($sformatf("redirect_pc %h, expected %h",
                                    $sampled(redirect_pc), exp_redirect));

    a_idle_no_flush: assert property (@(posedge clk) disable iff (!rstn)
        !chk_stage |-> !flush)
        else report_error("flush high with an empty stage");

    a_excp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush == exp_excp)
        else report_error($sformatf("excp_flush %b, expected %b", $sampled(excp_flush), exp_excp));

    a_ertn_pulse: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush == exp_ertn)
        else report_error($sformatf("ertn_flush %b, expected %b", $sampled(ertn_flush), exp_ertn));

    a_crmd: assert property (@(posedge clk) disable iff (!rstn)
        crmd == m_crmd)
        else report_error($sformatf("crmd %h, expected %h", $sampled(crmd), m_crmd));

    initial
    begin
        #(watchdog_ns);
        $display(">>> FAIL");
        $display("timeout: the test sequence did not finish in time");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int                   loops;
        int                   ints_before;
        logic [csr_num_w-1:0] nums [0:5];
        nums      = '{csr_save0, csr_save1, csr_save2, csr_save3, csr_era, csr_eentry};
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_op    = op_csrrd;
        req_arg   = '0;
        req_pc    = '0;
        req_din   = '0;
        req_mask  = '0;
        req_badv  = '0;
        stall     = 1'b0;
        hw_int    = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        read_csr(csr_crmd);

        // read, write and exchange
        for (int i = 0; i < 6; i++)
            write_csr(nums[i], next_bits(32));
        write_csr(csr_tid, next_bits(32));
        for (int i = 0; i < 6; i++)
            read_csr(nums[i]);
        read_csr(csr_tid);
        for (int i = 0; i < 4; i++)
        begin
            run_req(op_csrxchg, num_arg(nums[i]), next_bits(32), next_bits(32), '0);
            read_csr(nums[i]);
        end

        // exception entry and return
        write_csr(csr_crmd, 32'h0000_000f);
        run_req(op_excp, excp_arg(ecode_sys, 9'(next_bits(9))), '0, '0, '0);
        read_csr(csr_estat);
        read_csr(csr_era);
        read_csr(csr_prmd);
        run_req(op_ertn, '0, '0, '0, '0);
        read_csr(csr_crmd);
        run_req(op_excp, excp_arg(ecode_ale, 9'(next_bits(9))), '0, '0, next_bits(32));
        read_csr(csr_badv);
        read_csr(csr_estat);
        run_req(op_ertn, '0, '0, '0, '0);

        // one-shot timer, init value 8
        write_csr(csr_ecfg, 32'h0000_0800);
        write_csr(csr_crmd, 32'h0000_000c);
        ints_before = int_count;
        write_csr(csr_tcfg, 32'h0000_0009);
        loops = 0;
        while (int_count == ints_before)
        begin
            if (loops > 16)
                report_error("no timer interrupt within init value plus 8 requests");
            read_csr(csr_save0);
            loops++;
        end
        read_csr(csr_estat);
        write_csr(csr_ticlr, 32'h0000_0001);
        read_csr(csr_estat);
        write_csr(csr_tcfg, 32'h0000_0000);

        // hardware line 0 masking
        hw_int = 8'h01;
        write_csr(csr_ecfg, 32'h0000_0004);    // lie set, ie still off
        read_csr(csr_save1);
        write_csr(csr_ecfg, 32'h0000_0800);
        write_csr(csr_crmd, 32'h0000_0004);    // ie on, lie clear
        read_csr(csr_save1);
        ints_before = int_count;
        write_csr(csr_ecfg, 32'h0000_0004);
        read_csr(csr_save2);
        if (int_count != ints_before + 1)
            report_error("hardware interrupt not taken with lie and ie set");
        hw_int = 8'h00;
        run_req(op_ertn, '0, '0, '0, '0);
        read_csr(csr_crmd);

        @(negedge clk);
        exp_excp = 1'b0;
        exp_ertn = 1'b0;
        repeat (2) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/csr_unit_properties.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_properties
(
    input wire logic clk,
    input wire logic rstn,
    input wire logic req_valid,
    input wire logic stall,
    input wire logic flush,
    input wire logic excp_flush,
    input wire logic ertn_flush
);

    logic rst_seen = 1'b0;    // one reset edge done

    always @(posedge clk)
    begin
        if (!rstn)
            rst_seen <= 1'b1;
    end

    a_flush_kinds_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
        else $error("excp_flush and ertn_flush high together");

    a_excp_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush |=> !excp_flush)
        else $error("excp_flush longer than one cycle");

    a_ertn_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush |=> !ertn_flush)
        else $error("ertn_flush longer than one cycle");

    // flush only follows an issued request
    a_flush_after_issue: assert property (@(posedge clk) disable iff (!rstn)
        $rose(flush) |-> $past(req_valid && !stall))
        else $error("flush rose without an issue the cycle before");

    a_quiet_in_reset: assert property (@(posedge clk)
        (!rstn && rst_seen) |-> (!flush && !excp_flush && !ertn_flush))
        else $error("pulse while in reset");

endmodule

bind csr_unit csr_unit_properties props_i (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .stall      (stall),
    .flush      (flush),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush)
);

`default_nettype wire

// File: source/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit
    import csr_map_pkg::*;
    import csr_op_pkg::*;
#(
    parameter int timer_n = 32
)
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            req_valid,
    input  csr_op_e         req_op,
    input  csr_arg_u        req_arg,
    input  logic [xlen-1:0] req_pc,
    input  logic [xlen-1:0] req_din,
    input  logic [xlen-1:0] req_mask,
    input  logic [xlen-1:0] req_badv,
    input  logic            stall,
    input  logic [7:0]      hw_int,
    output logic [xlen-1:0] rdata,
    output logic            flush,
    output logic [xlen-1:0] redirect_pc,
    output logic            excp_flush,
    output logic            ertn_flush,
    output logic [8:0]      crmd
);

    logic [csr_num_w-1:0] rd_num;
    logic [xlen-1:0]      rd_data_regs;
    logic [xlen-1:0]      rd_data_timer;
    logic                 int_request;
    logic                 ti_pending;
    logic [xlen-1:0]      era;
    logic [xlen-1:0]      eentry;
    logic                 commit;
    csr_op_e              commit_op;
    csr_arg_u             commit_arg;
    logic [xlen-1:0]      commit_pc;
    logic [xlen-1:0]      commit_wdata;
    logic [xlen-1:0]      commit_badv;

    csr_trap trap_i (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_arg       (req_arg),
        .req_pc        (req_pc),
        .req_din       (req_din),
        .req_mask      (req_mask),
        .req_badv      (req_badv),
        .stall         (stall),
        .rd_data_regs  (rd_data_regs),
        .rd_data_timer (rd_data_timer),
        .int_request   (int_request),
        .era           (era),
        .eentry        (eentry),
        .rd_num        (rd_num),
        .rdata         (rdata),
        .flush         (flush),
        .redirect_pc   (redirect_pc),
        .excp_flush    (excp_flush),
        .ertn_flush    (ertn_flush),
        .commit        (commit),
        .commit_op     (commit_op),
        .commit_arg    (commit_arg),
        .commit_pc     (commit_pc),
        .commit_wdata  (commit_wdata),
        .commit_badv   (commit_badv)
    );

    csr_regs regs_i (
        .clk          (clk),
        .rstn         (rstn),
        .commit       (commit),
        .commit_op    (commit_op),
        .commit_arg   (commit_arg),
        .commit_pc    (commit_pc),
        .commit_wdata (commit_wdata),
        .commit_badv  (commit_badv),
        .rd_num       (rd_num),
        .hw_int       (hw_int),
        .ti_pending   (ti_pending),
        .rd_data      (rd_data_regs),
        .int_request  (int_request),
        .era          (era),
        .eentry       (eentry),
        .crmd         (crmd)
    );

    csr_timer #(
        .timer_n (timer_n)
    ) timer_i (
        .clk          (clk),
        .rstn         (rstn),
        .commit       (commit),
        .commit_op    (commit_op),
        .commit_arg   (commit_arg),
        .commit_wdata (commit_wdata),
        .rd_num       (rd_num),
        .rd_data      (rd_data_timer),
        .ti_pending   (ti_pending)
    );

endmodule

`default_nettype wire

// File: source/csr_trap.sv
`timescale 1ns/10ps
`default_nettype none

module csr_trap
    import csr_map_pkg::*;
    import csr_op_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req_valid,
    input  csr_op_e              req_op,
    input  csr_arg_u             req_arg,
    input  logic [xlen-1:0]      req_pc,
    input  logic [xlen-1:0]      req_din,
    input  logic [xlen-1:0]      req_mask,
    input  logic [xlen-1:0]      req_badv,
    input  logic                 stall,
    input  logic [xlen-1:0]      rd_data_regs,
    input  logic [xlen-1:0]      rd_data_timer,
    input  logic                 int_request,
    input  logic [xlen-1:0]      era,
    input  logic [xlen-1:0]      eentry,
    output logic [csr_num_w-1:0] rd_num,
    output logic [xlen-1:0]      rdata,
    output logic                 flush,
    output logic [xlen-1:0]      redirect_pc,
    output logic                 excp_flush,
    output logic                 ertn_flush,
    output logic                 commit,
    output csr_op_e              commit_op,
    output csr_arg_u             commit_arg,
    output logic [xlen-1:0]      commit_pc,
    output logic [xlen-1:0]      commit_wdata,
    output logic [xlen-1:0]      commit_badv
);

    logic            issue;
    logic            int_block;
    logic            take_int;
    logic [xlen-1:0] old_val;
    logic [xlen-1:0] mask;
    logic [xlen-1:0] merged;
    csr_op_e         op_in;
    csr_arg_u        arg_in;
    logic            stage_valid;
    csr_op_e         stage_op;
    csr_arg_u        stage_arg;
    logic [xlen-1:0] stage_pc;
    logic [xlen-1:0] stage_wdata;
    logic [xlen-1:0] stage_badv;

    assign issue  = req_valid && !stall;
    assign rd_num = req_arg.csr.num;

    // read, then mask merge against the old value
    assign old_val = rd_data_regs | rd_data_timer;
    assign mask    = (req_op == op_csrwr) ? '1 : req_mask;
    assign merged  = (old_val & ~mask) | (req_din & mask);

    // no second trap while one is still waiting to commit
    assign int_block = stage_valid && (stage_op == op_excp || stage_op == op_int);
    assign take_int  = int_request && !int_block;

    always_comb
    begin
        op_in  = req_op;
        arg_in = req_arg;
        if (take_int)
        begin
            op_in             = op_int;
            arg_in            = '0;
            arg_in.excp.ecode = ecode_int;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            stage_valid <= 1'b0;
            stage_op    <= op_csrrd;
            rdata       <= '0;
        end
        else if (!stall)
        begin
            stage_valid <= req_valid;
            if (req_valid)
            begin
                stage_op <= op_in;
                rdata    <= old_val;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            stage_arg   <= arg_in;
            stage_pc    <= req_pc;
            stage_wdata <= merged;
            stage_badv  <= req_badv;
        end
    end

    assign commit       = stage_valid && !stall;
    assign commit_op    = stage_op;
    assign commit_arg   = stage_arg;
    assign commit_pc    = stage_pc;
    assign commit_wdata = stage_wdata;
    assign commit_badv  = stage_badv;

    assign flush = stage_valid && (stage_op != op_csrrd);    // held with the stage

    always_comb
    begin
        case (stage_op)
            op_ertn:         redirect_pc = era;
            op_excp, op_int: redirect_pc = eentry;
            default:         redirect_pc = stage_pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= commit && (stage_op == op_excp || stage_op == op_int);
            ertn_flush <= commit && (stage_op == op_ertn);
        end
    end

endmodule

`default_nettype wire

// File: source/csr_timer.sv
`timescale 1ns/10ps
`default_nettype none

module csr_timer
    import csr_map_pkg::*;
    import csr_op_pkg::*;
#(
    parameter int timer_n = 32
)
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 commit,
    input  csr_op_e              commit_op,
    input  csr_arg_u             commit_arg,
    input  logic [xlen-1:0]      commit_wdata,
    input  logic [csr_num_w-1:0] rd_num,
    output logic [xlen-1:0]      rd_data,
    output logic                 ti_pending
);

    logic [xlen-1:0]    tid;
    logic [timer_n-1:0] tcfg;
    logic [timer_n-1:0] tval;
    logic               tcfg_change;
    logic               wr_en;
    logic               ti_clear;
    logic               enable;
    logic               periodic;

    assign wr_en    = commit && (commit_op == op_csrwr || commit_op == op_csrxchg);
    assign ti_clear = wr_en && commit_arg.csr.num == csr_ticlr && commit_wdata[ticlr_clr_bit];
    assign enable   = tcfg[0];
    assign periodic = tcfg[1];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tid         <= '0;
            tcfg        <= '0;
            tcfg_change <= 1'b0;
        end
        else
        begin
            tcfg_change <= 1'b0;
            if (wr_en && commit_arg.csr.num == csr_tid)
                tid <= commit_wdata;
            if (wr_en && commit_arg.csr.num == csr_tcfg)
            begin
                tcfg        <= commit_wdata[timer_n-1:0];
                tcfg_change <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval       <= '0;
            ti_pending <= 1'b0;
        end
        else
        begin
            if (!enable)
                tval <= '0;
            else if (tcfg_change || (tval == '0 && periodic))
                tval <= {tcfg[timer_n-1:2], 2'b00};    // init value
            else if (tval != '1)
                tval <= tval - 1'b1;    // one-shot parks at all ones

            if (ti_clear)
                ti_pending <= 1'b0;
            else if (tval == '0 && enable && !tcfg_change)
                ti_pending <= 1'b1;
        end
    end

    always_comb
    begin
        case (rd_num)
            csr_tid:  rd_data = tid;
            csr_tcfg: rd_data = xlen'(tcfg);
            csr_tval: rd_data = xlen'(tval);
            default:  rd_data = '0;    // ticlr reads zero too
        endcase
    end

endmodule

`default_nettype wire

// File: source/csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regs
    import csr_map_pkg::*;
    import csr_op_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 commit,
    input  csr_op_e              commit_op,
    input  csr_arg_u             commit_arg,
    input  logic [xlen-1:0]      commit_pc,
    input  logic [xlen-1:0]      commit_wdata,
    input  logic [xlen-1:0]      commit_badv,
    input  logic [csr_num_w-1:0] rd_num,
    input  logic [7:0]           hw_int,
    input  logic                 ti_pending,
    output logic [xlen-1:0]      rd_data,
    output logic                 int_request,
    output logic [xlen-1:0]      era,
    output logic [xlen-1:0]      eentry,
    output logic [8:0]           crmd
);

    localparam logic [lie_timer_bit:0] lie_wmask = 12'hbff;    // bit 10 reserved

    logic [2:0]                 prmd;
    logic [lie_timer_bit:0]     lie;
    logic [1:0]                 estat_is;
    logic [ecode_w-1:0]         estat_ecode;
    logic [esubcode_w-1:0]      estat_esubcode;
    logic [xlen-1:0]            badv;
    logic [xlen-1:eentry_lsb]   eentry_hi;
    logic [xlen-1:0]            save0;
    logic [xlen-1:0]            save1;
    logic [xlen-1:0]            save2;
    logic [xlen-1:0]            save3;
    logic [lie_timer_bit:0]     is_vec;
    logic                       wr_en;
    logic                       trap_en;
    logic                       ertn_en;
    logic [csr_num_w-1:0]       wnum;

    assign wr_en   = commit && (commit_op == op_csrwr || commit_op == op_csrxchg);
    assign trap_en = commit && (commit_op == op_excp || commit_op == op_int);
    assign ertn_en = commit && (commit_op == op_ertn);
    assign wnum    = commit_arg.csr.num;
    assign eentry  = {eentry_hi, {eentry_lsb{1'b0}}};

    // pending lines, hw and timer sampled live
    always_comb
    begin
        is_vec                = '0;
        is_vec[1:0]           = estat_is;
        is_vec[9:2]           = hw_int;
        is_vec[lie_timer_bit] = ti_pending;
    end

    assign int_request = (|(is_vec & lie)) & crmd[crmd_ie_bit];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= crmd_reset;
            prmd           <= '0;
            lie            <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end
        else if (trap_en)
        begin
            prmd           <= crmd[2:0];
            crmd[2:0]      <= 3'b000;    // plv0, ie off
            estat_ecode    <= commit_arg.excp.ecode;
            estat_esubcode <= commit_arg.excp.esubcode;
        end
        else if (ertn_en)
        begin
            crmd[2:0] <= prmd;
        end
        else if (wr_en)
        begin
            case (wnum)
                csr_crmd:
                begin
                    crmd[2:0] <= commit_wdata[2:0];
                    crmd[8:5] <= commit_wdata[8:5];
                    // da/pg only move to a legal pair
                    if (commit_wdata[crmd_pg_bit] ^ commit_wdata[crmd_da_bit])
                        crmd[crmd_pg_bit:crmd_da_bit] <= commit_wdata[crmd_pg_bit:crmd_da_bit];
                end
                csr_prmd:  prmd     <= commit_wdata[2:0];
                csr_ecfg:  lie      <= commit_wdata[lie_timer_bit:0] & lie_wmask;
                csr_estat: estat_is <= commit_wdata[1:0];    // only sw bits writable
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (trap_en)
        begin
            era <= commit_pc;
            if (commit_arg.excp.ecode == ecode_ale || commit_arg.excp.ecode == ecode_ade)
                badv <= commit_badv;
        end
        else if (wr_en)
        begin
            case (wnum)
                csr_era:    era       <= commit_wdata;
                csr_badv:   badv      <= commit_wdata;
                csr_eentry: eentry_hi <= commit_wdata[xlen-1:eentry_lsb];
                csr_save0:  save0     <= commit_wdata;
                csr_save1:  save1     <= commit_wdata;
                csr_save2:  save2     <= commit_wdata;
                csr_save3:  save3     <= commit_wdata;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        rd_data = '0;
        case (rd_num)
            csr_crmd:   rd_data = xlen'(crmd);
            csr_prmd:   rd_data = xlen'(prmd);
            csr_ecfg:   rd_data = xlen'(lie);
            csr_estat:  rd_data = {1'b0, estat_esubcode, estat_ecode, 4'b0000, is_vec};
            csr_era:    rd_data = era;
            csr_badv:   rd_data = badv;
            csr_eentry: rd_data = eentry;
            csr_save0:  rd_data = save0;
            csr_save1:  rd_data = save1;
            csr_save2:  rd_data = save2;
            csr_save3:  rd_data = save3;
            default:    rd_data = '0;    // timer block or unmapped
        endcase
    end

endmodule

`default_nettype wire

// File: source/csr_op_pkg.sv
`default_nettype none

package csr_op_pkg;

    localparam int xlen       = 32;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;

    // op_int never comes from the pipeline
    typedef enum logic [2:0] {
        op_csrrd   = 3'd0,
        op_csrwr   = 3'd1,
        op_csrxchg = 3'd2,
        op_ertn    = 3'd3,
        op_excp    = 3'd4,
        op_int     = 3'd5
    } csr_op_e;

    // argument word, csr number or exception codes
    typedef union packed {
        struct packed {
            logic [1:0]                       spare;
            logic [csr_map_pkg::csr_num_w-1:0] num;
        } csr;
        struct packed {
            logic                  spare;
            logic [esubcode_w-1:0] esubcode;
            logic [ecode_w-1:0]    ecode;
        } excp;
    } csr_arg_u;

endpackage

`default_nettype wire

// File: source/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

    localparam int csr_num_w = 14;

    // basic csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h007;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h031;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h032;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h033;
    localparam logic [csr_num_w-1:0] csr_tid    = 14'h040;
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h041;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h042;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h044;

    // crmd layout
    localparam int crmd_ie_bit = 2;
    localparam int crmd_da_bit = 3;
    localparam int crmd_pg_bit = 4;
    localparam logic [8:0] crmd_reset = 9'b0_0000_1000;    // da=1, plv0, ie off

    localparam int lie_timer_bit = 11;   // timer line in lie and is
    localparam int ticlr_clr_bit = 0;
    localparam int eentry_lsb    = 6;

    // exception codes
    localparam logic [5:0] ecode_int = 6'h00;
    localparam logic [5:0] ecode_ade = 6'h08;
    localparam logic [5:0] ecode_ale = 6'h09;
    localparam logic [5:0] ecode_sys = 6'h0b;
    localparam logic [5:0] ecode_brk = 6'h0c;
    localparam logic [5:0] ecode_ine = 6'h0d;

endpackage

`default_nettype wire
